// ==== files.f ====
+incdir+source
source/spi_bus_pkg.sv
source/spi_host_pkg.sv
source/spi_byte_fifo.sv
source/spi_sequencer.sv
source/spi_rx_capture.sv
source/spi_wb_regs.sv
source/spi_master_top.sv
bench/tb_clock_gen.sv
bench/tb_spi_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_spi_master \
  -f files.f --Mdir "$build_dir" -o Vtb_spi_master
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_spi_master" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
fi

# The log decides the result
if grep -qF '** PASS **' "$log_file"; then
  echo "Result: passed"
  exit 0
fi
echo "Result: failed"
exit 1

// ==== bench/tb_spi_master.sv ====
`timescale 1ns/1ps
`include "spi_macros.svh"

module tb_spi_master
  import spi_bus_pkg::*;
  import spi_host_pkg::*;
();

  localparam int c_ack_timeout = 50;     // Cycles to wait for a Wishbone ack
  localparam int c_idle_polls = 2000;    // STATUS reads before giving up
  localparam int c_rst_timeout = 100;
  localparam int c_log_size = 1024;      // Bus bits kept per run

  logic    clk;
  logic    srst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    cipo = 1'b0;
  logic    sck;
  logic    csn;
  logic    copi;

  // Slave model state
  logic sck_q;
  logic csn_q;
  int   rise_cnt;                 // Rising SCK edges since reset
  int   csn_fall_cnt;
  int   fall_cnt;                 // Falling SCK edges in the current frame
  int   rx_bit_idx;
  logic copi_log [c_log_size];    // COPI at each rising SCK, by edge number

  // Loaded by the tests before each transaction
  int        skip_falls;          // SCK falls before the first RX bit goes out
  int        rx_bit_total;
  logic      rx_bits [c_log_size];
  spi_byte_t tx_bytes [$];
  spi_byte_t rx_pat [$];

  tb_clock_gen u_tb_clock_gen (
    .o_clk  (clk),
    .o_srst (srst)
  );

  spi_master_top u_spi_master_top (
    .i_ext_spi_clk_x (clk),
    .i_srst          (srst),
    .i_wb_req        (wb_req),
    .i_cipo          (cipo),
    .o_wb_rsp        (wb_rsp),
    .o_sck           (sck),
    .o_csn           (csn),
    .o_copi          (copi)
  );

  ////////////////////////////////////////////////////////////////////////////
  // SPI slave model, runs on the falling system clock
  ////////////////////////////////////////////////////////////////////////////

  task automatic shift_cipo_bit();
    if (rx_bit_idx < rx_bit_total) cipo = rx_bits[rx_bit_idx];
    else cipo = 1'b0;                     // Idle line after the pattern
    rx_bit_idx++;
  endtask

  always @(negedge clk) begin
    if (srst) begin
      sck_q = 1'b0;
      csn_q = 1'b1;
      rise_cnt = 0;
      csn_fall_cnt = 0;
      fall_cnt = 0;
      rx_bit_idx = 0;
      cipo = 1'b0;
    end else begin
      if (csn_q && !csn) begin            // New frame
        csn_fall_cnt++;
        fall_cnt = 0;
        rx_bit_idx = 0;
        if (skip_falls == 0) shift_cipo_bit();
      end
      if (!sck_q && sck) begin            // Mode 0, master samples here too
        if (rise_cnt < c_log_size) copi_log[rise_cnt] = copi;
        rise_cnt++;
      end
      if (!csn && sck_q && !sck) begin
        fall_cnt++;
        if (fall_cnt >= skip_falls) shift_cipo_bit();   // Next bit for the master
      end
      sck_q = sck;
      csn_q = csn;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure report and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%02h, expected 0x%02h", name, got, exp));
  endtask

  task automatic check_status(input string name, input spi_status_t got,
                              input spi_status_t exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_count(input string name, input integer got, input integer exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone host
  ////////////////////////////////////////////////////////////////////////////

  // One classic cycle, stb held until ack
  task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(negedge clk);
      waited++;
      if (waited > c_ack_timeout)
        abort_run($sformatf("Wishbone access to address %0d was never acknowledged", adr));
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we = 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic read_status(output spi_status_t st);
    wb_data_t d;
    wb_read(`SPI_ADR_STATUS, d);
    st = spi_status_t'(d[$bits(spi_status_t)-1:0]);
  endtask

  // Poll STATUS until the master reports idle
  task automatic wait_idle();
    spi_status_t st;
    int polls;
    polls = 0;
    read_status(st);
    while (!st.idle) begin
      polls++;
      if (polls > c_idle_polls) abort_run("The master never returned to idle");
      read_status(st);
    end
  endtask

  // Reset is sampled on the rising edge, where it is stable
  task automatic wait_reset_release();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > c_rst_timeout) abort_run("Reset was never released");
    end while (srst);
    @(negedge clk);
  endtask

  function automatic wb_data_t ctrl_word(input int tx_len, input int rx_len,
                                         input int wait_cyc);
    spi_ctrl_t c;
    c = '0;
    c.go = 1'b1;
    c.tx_len = spi_len_t'(tx_len);
    c.rx_len = spi_len_t'(rx_len);
    c.wait_cyc = spi_wait_t'(wait_cyc);
    return wb_data_t'(c);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transaction helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_tx_bytes();
    foreach (tx_bytes[i]) wb_write(`SPI_ADR_TXDATA, wb_data_t'(tx_bytes[i]));
  endtask

  // Expand rx_pat into bits for the slave, MSB first
  task automatic load_slave(input int skip);
    foreach (rx_pat[i]) begin
      for (int b = 0; b < 8; b++) rx_bits[8 * i + b] = rx_pat[i][7 - b];
    end
    rx_bit_total = 8 * rx_pat.size();
    skip_falls = skip;
  endtask

  task automatic check_copi_bytes(input int first_rise);
    spi_byte_t got;
    foreach (tx_bytes[i]) begin
      for (int b = 0; b < 8; b++) got[7 - b] = copi_log[first_rise + 8 * i + b];
      check_byte($sformatf("o_copi byte %0d", i), got, tx_bytes[i]);
    end
  endtask

  task automatic drain_rx();
    wb_data_t d;
    foreach (rx_pat[i]) begin
      wb_read(`SPI_ADR_RXDATA, d);
      check_byte($sformatf("rxdata byte %0d", i), d[7:0], rx_pat[i]);
    end
  endtask

  // Full transaction from tx_bytes and rx_pat, checked end to end
  task automatic run_xfer(input int wait_cyc);
    int n_tx;
    int n_rx;
    int eff_wait;
    int rise0;
    int csn0;
    spi_status_t st;
    spi_status_t exp_st;
    n_tx = tx_bytes.size();
    n_rx = rx_pat.size();
    eff_wait = (n_rx == 0) ? 0 : wait_cyc;     // No WAIT phase without RX bytes
    push_tx_bytes();
    load_slave(8 * n_tx + eff_wait);
    rise0 = rise_cnt;
    csn0 = csn_fall_cnt;
    wb_write(`SPI_ADR_CTRL, ctrl_word(n_tx, n_rx, wait_cyc));
    wait_idle();
    check_count("sck rising edges", rise_cnt - rise0, 8 * (n_tx + n_rx) + eff_wait);
    check_count("csn falling edges", csn_fall_cnt - csn0, 1);
    check_bit("o_csn", csn, 1'b1);
    check_copi_bytes(rise0);
    read_status(st);
    exp_st = '{idle: 1'b1, tx_ready: 1'b1, rx_avail: (n_rx != 0)};
    check_status("status after transfer", st, exp_st);
    drain_rx();
    read_status(st);
    exp_st.rx_avail = 1'b0;                     // All RX bytes read out
    check_status("status after reads", st, exp_st);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_defaults();
    spi_status_t st;
    check_bit("o_csn", csn, 1'b1);
    check_bit("o_sck", sck, 1'b0);
    check_bit("o_copi", copi, 1'b0);
    check_bit("o_wb_rsp.ack", wb_rsp.ack, 1'b0);
    read_status(st);
    check_status("status after reset", st, '{idle: 1'b1, tx_ready: 1'b1, rx_avail: 1'b0});
  endtask

  task automatic tx_only_xfer();
    tx_bytes = '{8'ha5, 8'h3c, 8'h81};
    rx_pat.delete();
    run_xfer(0);
  endtask

  task automatic tx_wait_rx_xfer();
    tx_bytes = '{8'h9f};
    rx_pat = '{8'hc3, 8'h5a};
    run_xfer(2);
  endtask

  // Second control write lands while the first transaction runs
  task automatic busy_ctrl_ignored();
    int rise0;
    int csn0;
    spi_status_t st;
    tx_bytes = '{8'h6e};
    rx_pat.delete();
    push_tx_bytes();
    load_slave(8);
    rise0 = rise_cnt;
    csn0 = csn_fall_cnt;
    wb_write(`SPI_ADR_CTRL, ctrl_word(1, 0, 0));
    wb_write(`SPI_ADR_CTRL, ctrl_word(2, 2, 1));
    wait_idle();
    check_count("sck rising edges", rise_cnt - rise0, 8);
    check_count("csn falling edges", csn_fall_cnt - csn0, 1);
    check_copi_bytes(rise0);
    read_status(st);
    check_status("status after busy write", st, '{idle: 1'b1, tx_ready: 1'b1, rx_avail: 1'b0});
  endtask

  task automatic random_xfers();
    int n_tx;
    int n_rx;
    int wait_cyc;
    for (int k = 0; k < 4; k++) begin
      n_tx = $urandom_range(4, 1);
      n_rx = $urandom_range(4, 0);
      wait_cyc = $urandom_range(3, 0);
      tx_bytes.delete();
      rx_pat.delete();
      repeat (n_tx) tx_bytes.push_back(spi_byte_t'($urandom));
      repeat (n_rx) rx_pat.push_back(spi_byte_t'($urandom));
      run_xfer(wait_cyc);
    end
  endtask

  initial begin
    wb_req = '0;
    skip_falls = 0;
    rx_bit_total = 0;
    void'($urandom(32'ha03d7e15));        // Single seed for the whole run
    wait_reset_release();
    reset_defaults();
    tx_only_xfer();
    tx_wait_rx_xfer();
    busy_ctrl_ignored();
    random_xfers();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int parm_half_ns = 4,       // 8 ns period
  parameter int parm_rst_cycles = 5
) (
  output logic o_clk,
  output logic o_srst
);

  initial begin
    o_clk = 1'b0;
    forever #(parm_half_ns) o_clk = ~o_clk;
  end

  // Reset over the first rising edges, released on a falling edge
  initial begin
    o_srst = 1'b1;
    repeat (parm_rst_cycles) @(posedge o_clk);
    @(negedge o_clk);
    o_srst = 1'b0;
  end

endmodule

// ==== source/spi_master_top.sv ====
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_master_top
  import spi_bus_pkg::*;
  import spi_host_pkg::*;
(
  input  logic    i_ext_spi_clk_x,
  input  logic    i_srst,
  input  wb_req_t i_wb_req,
  input  logic    i_cipo,
  output wb_rsp_t o_wb_rsp,
  output logic    o_sck,
  output logic    o_csn,
  output logic    o_copi
);

  // TX path
  logic       tx_push;
  spi_byte_t  tx_wr_byte;
  logic       tx_pop;
  spi_byte_t  tx_head;
  logic       tx_empty;
  logic       tx_full;
  // RX path
  logic       rx_push;
  spi_byte_t  rx_wr_byte;
  logic       rx_pop;
  spi_byte_t  rx_head;
  logic       rx_empty;
  logic       rx_full;
  // Sequencer control
  logic       start;
  spi_xfer_t  xfer;
  logic       idle;
  spi_state_t state;
  spi_timer_t timer;
  logic       cap_phase;

  spi_wb_regs u_spi_wb_regs (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_wb_req        (i_wb_req),
    .i_idle          (idle),
    .i_tx_full       (tx_full),
    .i_rx_empty      (rx_empty),
    .i_rx_byte       (rx_head),
    .o_wb_rsp        (o_wb_rsp),
    .o_tx_push       (tx_push),
    .o_tx_byte       (tx_wr_byte),
    .o_rx_pop        (rx_pop),
    .o_start         (start),
    .o_xfer          (xfer)
  );

  spi_byte_fifo #(.parm_depth_log2(`SPI_FIFO_DEPTH_LOG2)) u_tx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_push          (tx_push),
    .i_data          (tx_wr_byte),
    .i_pop           (tx_pop),
    .o_data          (tx_head),
    .o_empty         (tx_empty),
    .o_full          (tx_full)
  );

  spi_sequencer u_spi_sequencer (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_start         (start),
    .i_xfer          (xfer),
    .i_tx_byte       (tx_head),
    .i_tx_empty      (tx_empty),
    .o_tx_pop        (tx_pop),
    .o_sck           (o_sck),
    .o_csn           (o_csn),
    .o_copi          (o_copi),
    .o_idle          (idle),
    .o_state         (state),
    .o_timer         (timer),
    .o_cap_phase     (cap_phase)
  );

  spi_rx_capture u_spi_rx_capture (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_cipo          (i_cipo),
    .i_state         (state),
    .i_timer         (timer),
    .i_rx_len        (xfer.rx_len),
    .i_cap_phase     (cap_phase),
    .i_rx_full       (rx_full),
    .o_push          (rx_push),
    .o_byte          (rx_wr_byte)
  );

  spi_byte_fifo #(.parm_depth_log2(`SPI_FIFO_DEPTH_LOG2)) u_rx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .i_push          (rx_push),
    .i_data          (rx_wr_byte),
    .i_pop           (rx_pop),
    .o_data          (rx_head),
    .o_empty         (rx_empty),
    .o_full          (rx_full)
  );

endmodule

// ==== source/spi_wb_regs.sv ====
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_wb_regs
  import spi_bus_pkg::*;
  import spi_host_pkg::*;
(
  input  logic      i_ext_spi_clk_x,
  input  logic      i_srst,
  input  wb_req_t   i_wb_req,
  input  logic      i_idle,
  input  logic      i_tx_full,
  input  logic      i_rx_empty,
  input  spi_byte_t i_rx_byte,
  output wb_rsp_t   o_wb_rsp,
  output logic      o_tx_push,
  output spi_byte_t o_tx_byte,
  output logic      o_rx_pop,
  output logic      o_start,
  output spi_xfer_t o_xfer
);

  logic        ack_q;
  logic        acc;          // New access, not yet acked
  logic        wr_tx;
  logic        rd_rx;
  logic        wr_ctrl;
  spi_ctrl_t   ctrl_w;       // Control word being written
  spi_ctrl_t   ctrl_rd;      // Control readback
  spi_status_t status_w;
  spi_xfer_t   xfer_q;
  wb_data_t    rd_data;
  wb_data_t    rd_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign acc = i_wb_req.cyc & i_wb_req.stb & ~ack_q;
  assign ctrl_w = spi_ctrl_t'(i_wb_req.dat);

  assign wr_tx = acc & i_wb_req.we & (i_wb_req.adr == `SPI_ADR_TXDATA);
  assign rd_rx = acc & ~i_wb_req.we & (i_wb_req.adr == `SPI_ADR_RXDATA);
  assign wr_ctrl = acc & i_wb_req.we & (i_wb_req.adr == `SPI_ADR_CTRL);

  assign o_tx_push = wr_tx & ~i_tx_full;     // Dropped when full
  assign o_tx_byte = i_wb_req.dat[7:0];
  assign o_rx_pop = rd_rx & ~i_rx_empty;
  assign o_start = wr_ctrl & ctrl_w.go & i_idle;   // Ignored while busy
  assign o_xfer = xfer_q;

  assign status_w.idle = i_idle;
  assign status_w.tx_ready = ~i_tx_full;
  assign status_w.rx_avail = ~i_rx_empty;

  assign ctrl_rd = '{
    rsvd:     '0,
    go:       ~i_idle,
    rx_len:   xfer_q.rx_len,
    tx_len:   xfer_q.tx_len,
    wait_cyc: xfer_q.wait_cyc
  };

  // Read mux
  always_comb begin
    rd_data = '0;
    case (i_wb_req.adr)
      `SPI_ADR_RXDATA: if (!i_rx_empty) rd_data[7:0] = i_rx_byte;   // Empty reads zero
      `SPI_ADR_CTRL:   rd_data = wb_data_t'(ctrl_rd);
      `SPI_ADR_STATUS: rd_data = {{($bits(wb_data_t) - $bits(spi_status_t)){1'b0}}, status_w};
      default:         rd_data = '0;   // TXDATA is write only
    endcase
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      ack_q <= 1'b0;
      xfer_q <= '0;
    end else begin
      ack_q <= acc;                        // Single-cycle ack
      if (o_start) begin
        xfer_q <= '{tx_len: ctrl_w.tx_len, rx_len: ctrl_w.rx_len, wait_cyc: ctrl_w.wait_cyc};
      end
    end
  end

  // Read data held with the ack
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (acc && !i_wb_req.we) rd_q <= rd_data;
  end

  assign o_wb_rsp.ack = ack_q;
  assign o_wb_rsp.dat = rd_q;

endmodule

// ==== source/spi_rx_capture.sv ====
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_rx_capture
  import spi_bus_pkg::*;
(
  input  logic       i_ext_spi_clk_x,
  input  logic       i_srst,
  input  logic       i_cipo,
  input  spi_state_t i_state,
  input  spi_timer_t i_timer,
  input  spi_len_t   i_rx_len,
  input  logic       i_cap_phase,
  input  logic       i_rx_full,
  output logic       o_push,
  output spi_byte_t  o_byte
);

  localparam int c_ext_bits = `SPI_LEN_BITS + 3;

  logic [1:0] cipo_sync;        // Two-flop synchronizer
  // One stage for the output register, two for the synchronizer
  spi_state_t state_d1;
  spi_state_t state_d2;
  spi_state_t state_d3;
  spi_timer_t timer_d1;
  spi_timer_t timer_d2;
  spi_timer_t timer_d3;
  logic in_rx;                  // Delayed state is RX and inside rx_len bytes
  logic last_bit;
  spi_byte_t shift_q;

  always_ff @(posedge i_ext_spi_clk_x) begin
    cipo_sync <= {cipo_sync[0], i_cipo};
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_d1 <= IDLE;
      state_d2 <= IDLE;
      state_d3 <= IDLE;
      timer_d1 <= '0;
      timer_d2 <= '0;
      timer_d3 <= '0;
    end else begin
      state_d1 <= i_state;
      state_d2 <= state_d1;
      state_d3 <= state_d2;
      timer_d1 <= i_timer;
      timer_d2 <= timer_d1;
      timer_d3 <= timer_d2;
    end
  end

  assign in_rx = (state_d3 == RX) && (c_ext_bits'(timer_d3) < {i_rx_len, 3'b000});
  assign last_bit = (timer_d3[2:0] == 3'b111);
  assign o_byte = shift_q;

  // Push strobe, byte lost when the RX FIFO is full
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) o_push <= 1'b0;
    else o_push <= i_cap_phase & in_rx & last_bit & ~i_rx_full;
  end

  // Shift MSB first, last bit lands with the push
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_cap_phase && in_rx) shift_q <= {shift_q[6:0], cipo_sync[1]};
  end

endmodule

// ==== source/spi_sequencer.sv ====
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_sequencer
  import spi_bus_pkg::*;
(
  input  logic       i_ext_spi_clk_x,
  input  logic       i_srst,
  input  logic       i_start,
  input  spi_xfer_t  i_xfer,
  input  spi_byte_t  i_tx_byte,
  input  logic       i_tx_empty,
  output logic       o_tx_pop,
  output logic       o_sck,
  output logic       o_csn,
  output logic       o_copi,
  output logic       o_idle,
  output spi_state_t o_state,
  output spi_timer_t o_timer,
  output logic       o_cap_phase
);

  localparam int c_cnt_bits = $clog2(`SPI_CLK_RATIO);
  localparam int c_ext_bits = `SPI_LEN_BITS + 3;     // Holds 8 * len
  localparam spi_timer_t c_guard_last = spi_timer_t'(`SPI_GUARD_SCK - 1);

  logic [c_cnt_bits-1:0] phase_cnt;
  logic ce0;            // Quarter 0, SCK rises
  logic ce2;            // Quarter 2, SCK falls
  logic sck_half;       // Free-running divided clock
  logic start_pend;     // Start seen, waiting for a falling quarter

  spi_state_t state;
  spi_state_t state_nx;
  spi_state_t after_tx;
  spi_state_t after_start;
  spi_timer_t timer;
  spi_timer_t wait_last;

  logic [c_ext_bits-1:0] tim_ext;
  logic [c_ext_bits-1:0] tx_last;
  logic [c_ext_bits-1:0] rx_last;
  logic guard_done;
  logic tx_done;
  logic tx_load;        // Take the FIFO head into the shifter
  spi_byte_t tx_byte_q;
  logic bus_run;
  logic cs_act;

  ////////////////////////////////////////////////////////////////////////////
  // Phase counter and quarter enables
  ////////////////////////////////////////////////////////////////////////////

  assign ce0 = (phase_cnt == '0);
  assign ce2 = (phase_cnt == c_cnt_bits'(`SPI_CLK_RATIO / 2));
  // RX capture lines up 3 cycles behind, on the falling quarter
  assign o_cap_phase = ce2;

  // Last timer value of each state
  assign tim_ext = c_ext_bits'(timer);
  assign tx_last = {i_xfer.tx_len - 1'b1, 3'b111};
  assign rx_last = {i_xfer.rx_len - 1'b1, 3'b111};
  assign wait_last = spi_timer_t'(i_xfer.wait_cyc) - 1'b1;
  assign guard_done = (timer == c_guard_last);
  assign tx_done = (tim_ext == tx_last);

  // Skip empty phases
  assign after_tx = (i_xfer.rx_len == '0) ? STOP_S :
                    (i_xfer.wait_cyc != '0) ? WAIT : RX;
  assign after_start = (i_xfer.tx_len != '0) ? TX : after_tx;

  always_comb begin
    state_nx = state;
    case (state)
      IDLE:    if (start_pend) state_nx = START_D;
      START_D: if (guard_done) state_nx = START_S;
      START_S: if (guard_done) state_nx = after_start;
      TX:      if (tx_done) state_nx = after_tx;
      WAIT:    if (timer == wait_last) state_nx = RX;
      RX:      if (tim_ext == rx_last) state_nx = STOP_S;
      STOP_S:  if (guard_done) state_nx = STOP_D;
      default: if (guard_done) state_nx = IDLE;   // STOP_D
    endcase
  end

  // First byte at end of START_S, then each byte boundary except the last
  assign tx_load = ce2 &
                   (((state == START_S) & guard_done & (i_xfer.tx_len != '0)) |
                    ((state == TX) & (timer[2:0] == 3'b111) & ~tx_done));
  assign o_tx_pop = tx_load & ~i_tx_empty;

  assign o_idle = (state == IDLE) & ~start_pend;
  assign o_state = state;
  assign o_timer = timer;

  assign bus_run = (state == TX) | (state == WAIT) | (state == RX);
  assign cs_act = (state != IDLE) & (state != START_D) & (state != STOP_D);

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      phase_cnt <= '0;
      sck_half <= 1'b0;
      start_pend <= 1'b0;
      state <= IDLE;
      timer <= '0;
    end else begin
      if (phase_cnt == c_cnt_bits'(`SPI_CLK_RATIO - 1)) phase_cnt <= '0;
      else phase_cnt <= phase_cnt + 1'b1;

      if (ce0) sck_half <= 1'b1;
      else if (ce2) sck_half <= 1'b0;

      if (i_start) start_pend <= 1'b1;
      else if (ce2 && state == IDLE) start_pend <= 1'b0;   // Consumed by IDLE exit

      // State and timer move on the falling quarter only
      if (ce2) begin
        state <= state_nx;
        if (state != state_nx) timer <= '0;
        else if (timer != '1) timer <= timer + 1'b1;    // Saturate
      end
    end
  end

  // Byte being shifted out, empty FIFO sends zeros
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (tx_load) tx_byte_q <= i_tx_empty ? '0 : i_tx_byte;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered bus outputs, Mode 0
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      o_sck <= 1'b0;
      o_csn <= 1'b1;
      o_copi <= 1'b0;
    end else begin
      o_sck <= sck_half & bus_run;          // Held low outside the data phases
      o_csn <= ~cs_act;
      o_copi <= (state == TX) ? tx_byte_q[3'd7 - timer[2:0]] : 1'b0;  // MSB first
    end
  end

endmodule

// ==== source/spi_byte_fifo.sv ====
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_byte_fifo
  import spi_bus_pkg::*;
#(
  parameter int parm_depth_log2 = `SPI_FIFO_DEPTH_LOG2
) (
  input  logic      i_ext_spi_clk_x,
  input  logic      i_srst,
  input  logic      i_push,
  input  spi_byte_t i_data,
  input  logic      i_pop,
  output spi_byte_t o_data,
  output logic      o_empty,
  output logic      o_full
);

  localparam int c_depth = 2 ** parm_depth_log2;

  spi_byte_t mem [c_depth];

  // Pointers carry one wrap bit above the index
  logic [parm_depth_log2:0] wr_ptr;
  logic [parm_depth_log2:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign o_empty = (wr_ptr == rd_ptr);
  // Same index, opposite wrap
  assign o_full = (wr_ptr[parm_depth_log2] != rd_ptr[parm_depth_log2]) &&
                  (wr_ptr[parm_depth_log2-1:0] == rd_ptr[parm_depth_log2-1:0]);

  assign do_push = i_push & ~o_full;   // Push to a full FIFO is dropped
  assign do_pop = i_pop & ~o_empty;

  assign o_data = mem[rd_ptr[parm_depth_log2-1:0]];  // Head, no read latency

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_push) mem[wr_ptr[parm_depth_log2-1:0]] <= i_data;
  end

endmodule

// ==== source/spi_host_pkg.sv ====
`include "spi_macros.svh"

// Types on the host side, Wishbone and register layouts
package spi_host_pkg;

  import spi_bus_pkg::*;

  typedef logic [1:0] wb_adr_t;    // Word address
  typedef logic [31:0] wb_data_t;

  // Host to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  // Slave to host
  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  // Unused upper bits of the control word
  localparam int c_ctrl_pad_bits = 32 - 1 - 2 * `SPI_LEN_BITS - `SPI_WAIT_BITS;

  // Control word, wait_cyc sits in the low bits
  typedef struct packed {
    logic [c_ctrl_pad_bits-1:0] rsvd;
    logic      go;         // Start, reads back as busy
    spi_len_t  rx_len;
    spi_len_t  tx_len;
    spi_wait_t wait_cyc;
  } spi_ctrl_t;

  typedef struct packed {
    logic idle;       // bit 2
    logic tx_ready;   // bit 1, TX FIFO has room
    logic rx_avail;   // bit 0, RX FIFO holds data
  } spi_status_t;

endpackage

// ==== source/spi_bus_pkg.sv ====
`include "spi_macros.svh"

// Types on the SPI side of the master
package spi_bus_pkg;

  typedef logic [7:0] spi_byte_t;                       // One bus byte
  typedef logic [`SPI_LEN_BITS-1:0] spi_len_t;          // Byte count
  typedef logic [`SPI_WAIT_BITS-1:0] spi_wait_t;        // Idle SCK count
  typedef logic [`SPI_TIMER_BITS-1:0] spi_timer_t;      // Per-state timer

  // Transaction sequence, CSN is low from START_S through STOP_S
  typedef enum logic [2:0] {
    IDLE,
    START_D,     // CSN high guard
    START_S,     // CSN low guard
    TX,
    WAIT,        // Free-running SCK, no data
    RX,
    STOP_S,      // CSN low guard
    STOP_D       // CSN high guard
  } spi_state_t;

  // Descriptor held for the whole transaction
  typedef struct packed {
    spi_len_t  tx_len;
    spi_len_t  rx_len;
    spi_wait_t wait_cyc;
  } spi_xfer_t;

endpackage

// ==== source/spi_macros.svh ====
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus timing
////////////////////////////////////////////////////////////////////////////

// System clocks per SCK period, a multiple of 4 and at least 8
`define SPI_CLK_RATIO 8
`define SPI_GUARD_SCK 4        // SCK periods of CSN guard, before and after

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////

`define SPI_FIFO_DEPTH_LOG2 4  // 16 bytes per FIFO
`define SPI_LEN_BITS 11        // TX and RX byte counts
`define SPI_WAIT_BITS 2        // Idle SCK cycles between TX and RX
`define SPI_TIMER_BITS 13      // Bit timer inside one state

// Wishbone word addresses
`define SPI_ADR_TXDATA 2'd0
`define SPI_ADR_RXDATA 2'd1
`define SPI_ADR_CTRL 2'd2
`define SPI_ADR_STATUS 2'd3

`endif
